// ==== common/rob_pkg.sv ====
// ****************************************************************************
// sizes, tag types and packet structs shared by the rename and commit back end
// ****************************************************************************

package rob_pkg;

    // instructions per cycle for dispatch, completion and retire
    localparam int n_way = 2;
    localparam int rob_depth = 8;
    localparam int arch_regs = 8;
    localparam int phys_regs = 16;

    // tags outside the initial identity map start on the free list
    // phys_regs - arch_regs >= rob_depth, so the free list never runs dry
    localparam int free_slots = phys_regs - arch_regs;

    typedef logic [$clog2(arch_regs)-1:0] arch_reg_idx;
    typedef logic [$clog2(phys_regs)-1:0] phys_reg_idx;

    // counts need one extra value for the full case
    typedef logic [$clog2(rob_depth+1)-1:0] rob_count;
    typedef logic [$clog2(n_way+1)-1:0] way_count;

    // pointer types, depths kept at powers of two so pointers wrap on overflow
    typedef logic [$clog2(rob_depth)-1:0] rob_idx;
    typedef logic [$clog2(free_slots)-1:0] free_idx;

    // one instruction offered by the producer
    typedef struct packed {
        logic valid;
        arch_reg_idx dest;
    } dispatch_packet;

    // reorder buffer entry
    // t is the newly allocated tag, told the tag it replaces
    typedef struct packed {
        logic valid;
        logic complete;
        arch_reg_idx dest;
        phys_reg_idx t;
        phys_reg_idx told;
    } rob_entry_packet;

    // tag broadcast by an execution unit
    typedef struct packed {
        logic valid;
        phys_reg_idx t;
    } complete_packet;

    // retiring instruction, told goes back to the free list
    typedef struct packed {
        arch_reg_idx dest;
        phys_reg_idx t;
        phys_reg_idx told;
    } retire_packet;

    // map table update from one dispatch way
    typedef struct packed {
        logic valid;
        arch_reg_idx dest;
        phys_reg_idx t;
    } map_write_packet;

endpackage

// ==== design/free_list.sv ====
// ****************************************************************************
// circular queue of free physical tags, popped at dispatch, refilled with the
// old tags of retiring instructions
// ****************************************************************************

`timescale 1ns/1ns

module free_list (
    input  logic clock,
    input  logic reset,
    input  rob_pkg::way_count pop_count,
    input  rob_pkg::phys_reg_idx [rob_pkg::n_way-1:0] push_tags,
    input  rob_pkg::way_count push_count,
    output rob_pkg::phys_reg_idx [rob_pkg::n_way-1:0] free_tags,
    output rob_pkg::phys_reg_idx free_count
);
    import rob_pkg::*;

    phys_reg_idx slots [free_slots];
    free_idx head;
    free_idx tail;
    phys_reg_idx count;

    // next n_way tags in queue order, way 0 gets the oldest
    always_comb begin
        for (int i = 0; i < n_way; i++) begin
            free_tags[i] = slots[free_idx'(head + free_idx'(i))];
        end
    end

    assign free_count = count;

    always_ff @(posedge clock) begin
        if (reset) begin
            // queue starts full with the tags above the identity map, ascending
            for (int i = 0; i < free_slots; i++) begin
                slots[i] <= phys_reg_idx'(arch_regs + i);
            end
            head <= '0;
            tail <= '0;
            count <= phys_reg_idx'(free_slots);
        end else begin
            // returned tags land at the tail in retire order
            for (int i = 0; i < n_way; i++) begin
                if (way_count'(i) < push_count) begin
                    slots[free_idx'(tail + free_idx'(i))] <= push_tags[i];
                end
            end
            head <= free_idx'(head + free_idx'(pop_count));
            tail <= free_idx'(tail + free_idx'(push_count));
            // pop and push in the same edge, count stays within free_slots
            // since every tag is either mapped, in flight or free
            count <= count - phys_reg_idx'(pop_count) + phys_reg_idx'(push_count);
        end
    end

endmodule

// ==== design/map_table.sv ====
// ****************************************************************************
// speculative map from architectural register to current physical tag,
// read by dispatch for old tags and written with the new tags it hands out
// ****************************************************************************

`timescale 1ns/1ns

module map_table (
    input  logic clock,
    input  logic reset,
    input  rob_pkg::arch_reg_idx [rob_pkg::n_way-1:0] lookup_dest,
    input  rob_pkg::map_write_packet [rob_pkg::n_way-1:0] map_write,
    output rob_pkg::phys_reg_idx [rob_pkg::n_way-1:0] lookup_tags
);
    import rob_pkg::*;

    phys_reg_idx map [arch_regs];

    // lookups see only the registered map
    // same-group forwarding is handled in dispatch
    always_comb begin
        for (int i = 0; i < n_way; i++) begin
            lookup_tags[i] = map[lookup_dest[i]];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map, register i lives in tag i
            for (int r = 0; r < arch_regs; r++) begin
                map[r] <= phys_reg_idx'(r);
            end
        end else begin
            // later ways are younger, so the last write to a register wins
            for (int i = 0; i < n_way; i++) begin
                if (map_write[i].valid) begin
                    map[map_write[i].dest] <= map_write[i].t;
                end
            end
        end
    end

endmodule

// ==== design/dispatch_rename.sv ====
// ****************************************************************************
// rename stage, pairs each accepted instruction with a free tag and its old
// tag, and decides how many of the offered instructions go in this cycle
// ****************************************************************************

`timescale 1ns/1ns

module dispatch_rename (
    input  rob_pkg::dispatch_packet [rob_pkg::n_way-1:0] dispatch,
    input  rob_pkg::phys_reg_idx [rob_pkg::n_way-1:0] free_tags,
    input  rob_pkg::phys_reg_idx free_count,
    input  rob_pkg::phys_reg_idx [rob_pkg::n_way-1:0] lookup_tags,
    input  rob_pkg::rob_count open_entries,
    output rob_pkg::arch_reg_idx [rob_pkg::n_way-1:0] lookup_dest,
    output rob_pkg::way_count pop_count,
    output rob_pkg::map_write_packet [rob_pkg::n_way-1:0] map_write,
    output rob_pkg::rob_entry_packet [rob_pkg::n_way-1:0] rob_wr_data,
    output rob_pkg::way_count rob_accept
);
    import rob_pkg::*;

    // accepted count, smallest of valid ways, open entries and free tags
    always_comb begin
        rob_count n_valid;
        rob_count accept;
        // valid ways are contiguous from way 0, count the leading run
        n_valid = '0;
        for (int i = 0; i < n_way; i++) begin
            if (dispatch[i].valid && n_valid == rob_count'(i)) begin
                n_valid = n_valid + 1'b1;
            end
        end
        accept = n_valid;
        if (open_entries < accept) begin
            accept = open_entries;
        end
        if (rob_count'(free_count) < accept) begin
            accept = rob_count'(free_count);
        end
        rob_accept = way_count'(accept);
    end

    // free list and reorder buffer advance by the same count
    assign pop_count = rob_accept;

    always_comb begin
        for (int i = 0; i < n_way; i++) begin
            lookup_dest[i] = dispatch[i].dest;
            rob_wr_data[i].valid = way_count'(i) < rob_accept;
            rob_wr_data[i].complete = 1'b0;
            rob_wr_data[i].dest = dispatch[i].dest;
            // way i takes the i-th free tag in queue order
            rob_wr_data[i].t = free_tags[i];
            // old tag from the map, unless an older way in this group
            // renames the same register, then the nearest such way wins
            rob_wr_data[i].told = lookup_tags[i];
            for (int j = 0; j < i; j++) begin
                if (dispatch[j].dest == dispatch[i].dest) begin
                    rob_wr_data[i].told = free_tags[j];
                end
            end
            map_write[i].valid = rob_wr_data[i].valid;
            map_write[i].dest = dispatch[i].dest;
            map_write[i].t = free_tags[i];
        end
    end

endmodule

// ==== rob/rob.sv ====
// ****************************************************************************
// n-way reorder buffer, entries enter at the tail from dispatch, are marked by
// completion tags, and retire in order from the head
// ****************************************************************************

`timescale 1ns/1ns

module rob (
    input  logic clock,
    input  logic reset,
    input  rob_pkg::rob_entry_packet [rob_pkg::n_way-1:0] wr_data,
    input  rob_pkg::way_count num_accept,
    input  rob_pkg::complete_packet [rob_pkg::n_way-1:0] complete,
    output rob_pkg::retire_packet [rob_pkg::n_way-1:0] retire_data,
    output rob_pkg::rob_count open_entries,
    output rob_pkg::way_count num_retired
);
    import rob_pkg::*;

    rob_entry_packet [rob_depth-1:0] entries;
    rob_entry_packet [rob_depth-1:0] next_entries;
    rob_idx head;
    rob_idx tail;
    rob_idx next_head;
    // explicit occupancy, head == tail alone is ambiguous between full and empty
    rob_count count;

    always_comb begin
        rob_idx slot;
        logic stop;

        next_entries = entries;
        retire_data = '0;
        num_retired = '0;
        next_head = head;
        stop = 1'b0;

        // completion marks registered valid entries whose tag matches
        for (int k = 0; k < rob_depth; k++) begin
            for (int j = 0; j < n_way; j++) begin
                if (entries[k].valid && complete[j].valid &&
                        entries[k].t == complete[j].t) begin
                    next_entries[k].complete = 1'b1;
                end
            end
        end

        // retire a run of complete entries from the head, stop at the first gap
        for (int i = 0; i < n_way; i++) begin
            slot = rob_idx'(head + rob_idx'(i));
            if (!stop && entries[slot].valid && entries[slot].complete) begin
                retire_data[i].dest = entries[slot].dest;
                retire_data[i].t = entries[slot].t;
                retire_data[i].told = entries[slot].told;
                next_entries[slot] = '0;
                next_head = rob_idx'(slot + 1'b1);
                num_retired = num_retired + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end

        // new entries go in after retirement so freed slots can be reused
        for (int i = 0; i < n_way; i++) begin
            if (way_count'(i) < num_accept) begin
                next_entries[rob_idx'(tail + rob_idx'(i))] = wr_data[i];
            end
        end
    end

    // free slots including those that retire this cycle
    assign open_entries = rob_count'(rob_depth) - count + rob_count'(num_retired);

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            entries <= next_entries;
            head <= next_head;
            tail <= rob_idx'(tail + rob_idx'(num_accept));
            count <= count + rob_count'(num_accept) - rob_count'(num_retired);
        end
    end

endmodule

// ==== design/backend_top.sv ====
// ****************************************************************************
// rename and commit back end, wires map table, free list, dispatch and the
// reorder buffer together behind the dispatch and completion ports
// ****************************************************************************

`timescale 1ns/1ns

module backend_top (
    input  logic clock,
    input  logic reset,
    input  rob_pkg::dispatch_packet [rob_pkg::n_way-1:0] dispatch,
    input  rob_pkg::complete_packet [rob_pkg::n_way-1:0] complete,
    output rob_pkg::way_count num_accept,
    output rob_pkg::rob_entry_packet [rob_pkg::n_way-1:0] renamed,
    output rob_pkg::retire_packet [rob_pkg::n_way-1:0] retiring,
    output rob_pkg::way_count num_retired
);
    import rob_pkg::*;

    phys_reg_idx [n_way-1:0] free_tags;
    phys_reg_idx free_count;
    phys_reg_idx [n_way-1:0] lookup_tags;
    arch_reg_idx [n_way-1:0] lookup_dest;
    way_count pop_count;
    map_write_packet [n_way-1:0] map_write;
    rob_count open_entries;
    phys_reg_idx [n_way-1:0] push_tags;

    // old tags of retiring instructions return to the free list
    for (genvar i = 0; i < n_way; i++) begin : g_push
        assign push_tags[i] = retiring[i].told;
    end

    free_list free_list0 (
        .clock      (clock),
        .reset      (reset),
        .pop_count  (pop_count),
        .push_tags  (push_tags),
        .push_count (num_retired),
        .free_tags  (free_tags),
        .free_count (free_count)
    );

    map_table map_table0 (
        .clock       (clock),
        .reset       (reset),
        .lookup_dest (lookup_dest),
        .map_write   (map_write),
        .lookup_tags (lookup_tags)
    );

    // renamed entries leave the top as they enter the reorder buffer
    dispatch_rename dispatch_rename0 (
        .dispatch     (dispatch),
        .free_tags    (free_tags),
        .free_count   (free_count),
        .lookup_tags  (lookup_tags),
        .open_entries (open_entries),
        .lookup_dest  (lookup_dest),
        .pop_count    (pop_count),
        .map_write    (map_write),
        .rob_wr_data  (renamed),
        .rob_accept   (num_accept)
    );

    rob rob0 (
        .clock        (clock),
        .reset        (reset),
        .wr_data      (renamed),
        .num_accept   (num_accept),
        .complete     (complete),
        .retire_data  (retiring),
        .open_entries (open_entries),
        .num_retired  (num_retired)
    );

endmodule

// ==== sim/tb_backend.sv ====
// ****************************************************************************
// testbench for the rename and commit back end, random dispatch and completion
// checked each cycle against a model map table, free queue and reorder buffer
// ****************************************************************************

`timescale 1ns/1ns

module tb_backend;
    import rob_pkg::*;

    localparam int half_period = 50;
    // reset, then one budget per test, then a margin
    localparam int cycle_limit = 10 + 40 + 40 + 80 + 60 + 600 + 200;

    logic clock;
    logic reset;
    dispatch_packet [n_way-1:0] dispatch;
    complete_packet [n_way-1:0] complete;
    way_count num_accept;
    rob_entry_packet [n_way-1:0] renamed;
    retire_packet [n_way-1:0] retiring;
    way_count num_retired;

    // reference state
    phys_reg_idx model_map [arch_regs];
    phys_reg_idx free_queue [$];
    rob_entry_packet model_rob [$];

    // producer queues in program order
    arch_reg_idx pending [$];
    phys_reg_idx outstanding [$];
    phys_reg_idx done_req [$];

    logic [31:0] lcg_state;
    int errors;
    int cycles;
    int retired_total;
    int tests_passed;
    int tests_failed;
    logic n_way_accept_seen;

    backend_top dut0 (
        .clock       (clock),
        .reset       (reset),
        .dispatch    (dispatch),
        .complete    (complete),
        .num_accept  (num_accept),
        .renamed     (renamed),
        .retiring    (retiring),
        .num_retired (num_retired)
    );

    always #half_period clock = ~clock;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // leading run of complete entries at the head up to n_way
    function automatic int retire_run();
        int n;
        n = 0;
        while (n < n_way && n < model_rob.size() && model_rob[n].complete) begin
            n++;
        end
        return n;
    endfunction

    // smallest of valid ways, open entries after retirement and free tags
    function automatic int expected_accept(int n_ret);
        int n_valid;
        int open;
        int acc;
        n_valid = 0;
        for (int i = 0; i < n_way; i++) begin
            if (dispatch[i].valid && n_valid == i) begin
                n_valid++;
            end
        end
        open = rob_depth - model_rob.size() + n_ret;
        acc = n_valid;
        if (open < acc) begin
            acc = open;
        end
        if (free_queue.size() < acc) begin
            acc = free_queue.size();
        end
        return acc;
    endfunction

    // new tag from the queue head, old tag from the nearest older same-dest way
    function automatic rob_entry_packet expected_entry(int way);
        rob_entry_packet e;
        e.valid = 1'b1;
        e.complete = 1'b0;
        e.dest = dispatch[way].dest;
        e.t = free_queue[way];
        e.told = model_map[e.dest];
        for (int j = 0; j < way; j++) begin
            if (dispatch[j].dest == e.dest) begin
                e.told = free_queue[j];
            end
        end
        return e;
    endfunction

    function automatic string entry_text(rob_entry_packet p);
        return $sformatf("v=%b c=%b dest=%0d t=%0d told=%0d",
            p.valid, p.complete, p.dest, p.t, p.told);
    endfunction

    function automatic string retire_text(retire_packet p);
        return $sformatf("dest=%0d t=%0d told=%0d", p.dest, p.t, p.told);
    endfunction

    task automatic check_count(string name, way_count exp, way_count act);
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_entry(string name, rob_entry_packet exp, rob_entry_packet act);
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected %s actual %s", $time, name,
                entry_text(exp), entry_text(act));
            errors++;
        end
    endtask

    task automatic check_retire(string name, retire_packet exp, retire_packet act);
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected %s actual %s", $time, name,
                retire_text(exp), retire_text(act));
            errors++;
        end
    endtask

    // compare outputs seen at the edge, then move the models across it
    always @(posedge clock) begin : check_outputs
        int n_ret;
        int n_acc;
        rob_entry_packet e;
        retire_packet r;
        rob_entry_packet new_e [n_way];
        if (!reset) begin
            n_ret = retire_run();
            n_acc = expected_accept(n_ret);
            check_count("num_retired", way_count'(n_ret), num_retired);
            for (int i = 0; i < n_ret; i++) begin
                r.dest = model_rob[i].dest;
                r.t = model_rob[i].t;
                r.told = model_rob[i].told;
                check_retire($sformatf("retiring[%0d]", i), r, retiring[i]);
            end
            check_count("num_accept", way_count'(n_acc), num_accept);
            for (int i = 0; i < n_way; i++) begin
                if (i < n_acc) begin
                    new_e[i] = expected_entry(i);
                    check_entry($sformatf("renamed[%0d]", i), new_e[i], renamed[i]);
                end else if (renamed[i].valid !== 1'b0) begin
                    $display("[ERROR] %0t renamed[%0d].valid expected 0 actual %b",
                        $time, i, renamed[i].valid);
                    errors++;
                end
            end
            if (num_accept == way_count'(n_way)) begin
                n_way_accept_seen = 1'b1;
            end
            retired_total += int'(num_retired);
            // completion marks entries already in the buffer
            for (int k = 0; k < model_rob.size(); k++) begin
                for (int j = 0; j < n_way; j++) begin
                    if (complete[j].valid && model_rob[k].t == complete[j].t) begin
                        e = model_rob[k];
                        e.complete = 1'b1;
                        model_rob[k] = e;
                    end
                end
            end
            // retired old tags join the free queue tail
            for (int i = 0; i < n_ret; i++) begin
                free_queue.push_back(model_rob[0].told);
                model_rob.delete(0);
            end
            for (int i = 0; i < n_acc; i++) begin
                free_queue.delete(0);
                model_map[new_e[i].dest] = new_e[i].t;
                model_rob.push_back(new_e[i]);
                outstanding.push_back(new_e[i].t);
            end
        end
    end

    // producer drops accepted ways, then offers the queue head on the falling edge
    initial begin : stimulus
        way_count taken;
        forever begin
            @(posedge clock);
            taken = num_accept;
            @(negedge clock);
            repeat (int'(taken)) pending.delete(0);
            for (int i = 0; i < n_way; i++) begin
                dispatch[i].valid = i < pending.size();
                dispatch[i].dest = (i < pending.size()) ? pending[i] : '0;
                if (done_req.size() > 0) begin
                    complete[i].valid = 1'b1;
                    complete[i].t = done_req.pop_front();
                end else begin
                    complete[i] = '0;
                end
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic wait_dispatched();
        while (pending.size() > 0) begin
            next_cycle();
        end
    endtask

    task automatic complete_all();
        while (outstanding.size() > 0) begin
            done_req.push_back(outstanding.pop_front());
        end
    endtask

    task automatic wait_empty();
        while (model_rob.size() > 0 || done_req.size() > 0) begin
            next_cycle();
        end
    endtask

    task automatic drain();
        wait_dispatched();
        complete_all();
        wait_empty();
    endtask

    task automatic report_test(string name, int start);
        if (errors == start) begin
            $display("test %s passed", name);
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", name, errors - start);
            tests_failed++;
        end
    endtask

    task automatic test_after_reset();
        int start;
        start = errors;
        pending.push_back(arch_reg_idx'(3));
        pending.push_back(arch_reg_idx'(5));
        drain();
        report_test("after_reset", start);
    endtask

    task automatic test_same_dest();
        int start;
        start = errors;
        // the third one lands in the next group and reads the map
        repeat (3) pending.push_back(arch_reg_idx'(4));
        drain();
        report_test("same_dest", start);
    endtask

    task automatic test_back_pressure();
        int start;
        start = errors;
        repeat (rob_depth + n_way) pending.push_back(arch_reg_idx'(lcg_next()));
        while (model_rob.size() < rob_depth) begin
            next_cycle();
        end
        // hold with nothing completing so the buffer stays full
        repeat (3) next_cycle();
        if (pending.size() != n_way || model_rob.size() != rob_depth) begin
            $display("full buffer kept accepting, %0d still waiting", pending.size());
            errors++;
        end
        n_way_accept_seen = 1'b0;
        repeat (n_way) done_req.push_back(outstanding.pop_front());
        wait_dispatched();
        if (!n_way_accept_seen) begin
            $display("full count never accepted after the head retired");
            errors++;
        end
        drain();
        report_test("back_pressure", start);
    endtask

    task automatic test_in_order_retire();
        int start;
        int retired_before;
        start = errors;
        repeat (4) pending.push_back(arch_reg_idx'(lcg_next()));
        wait_dispatched();
        retired_before = retired_total;
        // younger three first while the oldest stays open
        for (int i = 1; i < 4; i++) begin
            done_req.push_back(outstanding[i]);
        end
        repeat (3) outstanding.delete(1);
        while (done_req.size() > 0) begin
            next_cycle();
        end
        repeat (3) next_cycle();
        if (retired_total != retired_before) begin
            $display("entries retired while the oldest was incomplete");
            errors++;
        end
        complete_all();
        wait_empty();
        if (retired_total != retired_before + 4) begin
            $display("retired %0d entries instead of 4", retired_total - retired_before);
            errors++;
        end
        report_test("in_order_retire", start);
    endtask

    task automatic test_tag_recycling();
        int start;
        int issued;
        int k;
        int idx;
        start = errors;
        issued = 0;
        while (issued < 120) begin
            next_cycle();
            if (pending.size() < n_way) begin
                k = int'(lcg_next() % 3);
                for (int i = 0; i < k && issued < 120; i++) begin
                    pending.push_back(arch_reg_idx'(lcg_next()));
                    issued++;
                end
            end
            // complete a random outstanding tag on most cycles
            if (outstanding.size() > 0 && lcg_next() % 4 != 0) begin
                idx = int'(lcg_next() % outstanding.size());
                done_req.push_back(outstanding[idx]);
                outstanding.delete(idx);
            end
        end
        drain();
        report_test("tag_recycling", start);
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        dispatch = '0;
        complete = '0;
        lcg_state = 32'h09c3b980;
        errors = 0;
        cycles = 0;
        retired_total = 0;
        tests_passed = 0;
        tests_failed = 0;
        n_way_accept_seen = 1'b0;
        for (int r = 0; r < arch_regs; r++) begin
            model_map[r] = phys_reg_idx'(r);
        end
        for (int i = 0; i < free_slots; i++) begin
            free_queue.push_back(phys_reg_idx'(arch_regs + i));
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // one idle cycle, num_accept and num_retired are seen at zero
        next_cycle();
        test_after_reset();
        test_same_dest();
        test_back_pressure();
        test_in_order_retire();
        test_tag_recycling();
        $display("tests passed %0d, failed %0d, errors %0d",
            tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
common/rob_pkg.sv
design/free_list.sv
design/map_table.sv
design/dispatch_rename.sv
rob/rob.sv
design/backend_top.sv
sim/tb_backend.sv

// ==== run.sh ====
#!/bin/sh
# builds the back end testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_backend -o tb_backend
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_backend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1
